// File: design/boardIo.sv
module boardIo #(
   parameter int addrWidth = 8
) (
   input  logic                   selected_clk,
   input  logic                   res,
   input  logic [addrWidth-1:0]   awaddr,
   input  logic                   awvalid,
   output logic                   awready,
   input  logic [31:0]            wdata,
   input  logic [3:0]             wstrb,
   input  logic                   wvalid,
   output logic                   wready,
   output boardPkg::axiResp_t     bresp,
   output logic                   bvalid,
   input  logic                   bready,
   input  logic [addrWidth-1:0]   araddr,
   input  logic                   arvalid,
   output logic                   arready,
   output logic [31:0]            rdata,
   output boardPkg::axiResp_t     rresp,
   output logic                   rvalid,
   input  logic                   rready,
   input  logic [3:0]             buttons,
   input  logic [15:0]            switches,
   output logic [15:0]            leds,
   input  boardPkg::dispSrc_t     displaySel,
   output logic [31:0]            displayData,
   output logic                   irq
);
   import boardPkg::*;

   logic        wrEn;
   regSel_t     wrSel;
   logic [31:0] wrData;
   logic [3:0]  wrStrb;
   logic        rdEn;
   regSel_t     rdSel;
   logic [31:0] portA;
   logic [31:0] portB;
   logic [31:0] portC;
   logic [31:0] portD;
   logic [31:0] ctrl;
   logic [31:0] arr;
   logic [31:0] ctr;
   logic [31:0] tmr;
   logic [31:0] status;

   busDecode #(
      .addrWidth (addrWidth)
   ) decoder (
      .selected_clk (selected_clk),
      .res          (res),
      .awaddr       (awaddr),
      .awvalid      (awvalid),
      .awready      (awready),
      .wdata        (wdata),
      .wstrb        (wstrb),
      .wvalid       (wvalid),
      .wready       (wready),
      .bresp        (bresp),
      .bvalid       (bvalid),
      .bready       (bready),
      .araddr       (araddr),
      .arvalid      (arvalid),
      .arready      (arready),
      .rresp        (rresp),
      .rvalid       (rvalid),
      .rready       (rready),
      .wrEn         (wrEn),
      .wrSel        (wrSel),
      .wrData       (wrData),
      .wrStrb       (wrStrb),
      .rdEn         (rdEn),
      .rdSel        (rdSel)
   );

   portTimer execUnit (
      .selected_clk (selected_clk),
      .res          (res),
      .wrEn         (wrEn),
      .wrSel        (wrSel),
      .wrData       (wrData),
      .wrStrb       (wrStrb),
      .portA        (portA),
      .portB        (portB),
      .portC        (portC),
      .portD        (portD),
      .ctrl         (ctrl),
      .arr          (arr),
      .ctr          (ctr),
      .tmr          (tmr),
      .status       (status)
   );

   resultSelect resultUnit (
      .selected_clk (selected_clk),
      .res          (res),
      .rdEn         (rdEn),
      .rdSel        (rdSel),
      .portA        (portA),
      .portB        (portB),
      .portC        (portC),
      .portD        (portD),
      .buttons      (buttons),
      .switches     (switches),
      .ctrl         (ctrl),
      .arr          (arr),
      .ctr          (ctr),
      .status       (status),
      .tmr          (tmr),
      .displaySel   (displaySel),
      .rdata        (rdata),
      .displayData  (displayData)
   );

   assign leds = portB[15:0];             // Low half of port B
   assign irq  = status[0];               // Sticky reached flag

endmodule

// File: design/boardPkg.sv
package boardPkg;

   // ########################################################################
   // Register map
   // ########################################################################

   typedef enum logic [3:0] {
      selPortA  = 4'd0,
      selPortB  = 4'd1,
      selPortC  = 4'd2,
      selPortD  = 4'd3,
      selPortI  = 4'd4,              // Buttons, read only
      selPortJ  = 4'd5,              // Switches, read only
      selCtrl   = 4'd6,
      selArr    = 4'd7,
      selCtr    = 4'd8,              // Read only
      selStatus = 4'd9,              // Bit 0 is write-1-to-clear
      selTmr    = 4'd10,             // Read only
      selNone   = 4'd15
   } regSel_t;

   localparam int unsigned offPortA  = 'h00;
   localparam int unsigned offPortB  = 'h04;
   localparam int unsigned offPortC  = 'h08;
   localparam int unsigned offPortD  = 'h0C;
   localparam int unsigned offPortI  = 'h10;
   localparam int unsigned offPortJ  = 'h14;
   localparam int unsigned offCtrl   = 'h18;
   localparam int unsigned offArr    = 'h1C;
   localparam int unsigned offCtr    = 'h20;
   localparam int unsigned offStatus = 'h24;
   localparam int unsigned offTmr    = 'h28;

   // ########################################################################
   // Bus and display
   // ########################################################################

   typedef enum logic [1:0] {
      busIdle      = 2'd0,
      busWriteResp = 2'd1,
      busReadResp  = 2'd2
   } busState_t;

   typedef enum logic [1:0] {
      respOkay   = 2'b00,
      respSlvErr = 2'b10
   } axiResp_t;

   // Same order as the board selector
   typedef enum logic [3:0] {
      dispPortA  = 4'd0,
      dispPortB  = 4'd1,
      dispPortC  = 4'd2,
      dispPortD  = 4'd3,
      dispTmr    = 4'd4,
      dispArr    = 4'd5,
      dispCtr    = 4'd6,
      dispStatus = 4'd7,
      dispPortI  = 4'd8,
      dispPortJ  = 4'd9
   } dispSrc_t;

endpackage

// File: design/busDecode.sv
module busDecode #(
   parameter int addrWidth = 8
) (
   input  logic                   selected_clk,
   input  logic                   res,
   // Write address and data
   input  logic [addrWidth-1:0]   awaddr,
   input  logic                   awvalid,
   output logic                   awready,
   input  logic [31:0]            wdata,
   input  logic [3:0]             wstrb,
   input  logic                   wvalid,
   output logic                   wready,
   // Write response
   output boardPkg::axiResp_t     bresp,
   output logic                   bvalid,
   input  logic                   bready,
   // Read address and response
   input  logic [addrWidth-1:0]   araddr,
   input  logic                   arvalid,
   output logic                   arready,
   output boardPkg::axiResp_t     rresp,
   output logic                   rvalid,
   input  logic                   rready,
   // Register side
   output logic                   wrEn,
   output boardPkg::regSel_t      wrSel,
   output logic [31:0]            wrData,
   output logic [3:0]             wrStrb,
   output logic                   rdEn,
   output boardPkg::regSel_t      rdSel
);
   import boardPkg::*;

   busState_t wrState;
   busState_t rdState;
   logic      wrAccept;
   logic      rdAccept;
   logic      wrLegal;

   function automatic regSel_t decodeAddr(input logic [addrWidth-1:0] addr);
      regSel_t sel;
      case (addr)
         addrWidth'(offPortA):  sel = selPortA;
         addrWidth'(offPortB):  sel = selPortB;
         addrWidth'(offPortC):  sel = selPortC;
         addrWidth'(offPortD):  sel = selPortD;
         addrWidth'(offPortI):  sel = selPortI;
         addrWidth'(offPortJ):  sel = selPortJ;
         addrWidth'(offCtrl):   sel = selCtrl;
         addrWidth'(offArr):    sel = selArr;
         addrWidth'(offCtr):    sel = selCtr;
         addrWidth'(offStatus): sel = selStatus;
         addrWidth'(offTmr):    sel = selTmr;
         default:               sel = selNone;   // Unmapped or unaligned
      endcase
      return sel;
   endfunction

   function automatic logic isWritable(input regSel_t sel);
      case (sel)
         selPortA, selPortB, selPortC, selPortD,
         selCtrl, selArr, selStatus: return 1'b1;
         default:                    return 1'b0;
      endcase
   endfunction

   // ########################################################################
   // Acceptance, write before read
   // ########################################################################

   assign wrAccept = awvalid && wvalid && (wrState == busIdle);
   assign rdAccept = arvalid && !wrAccept && (rdState == busIdle);

   assign awready = wrAccept;
   assign wready  = wrAccept;
   assign arready = rdAccept;

   assign wrSel   = decodeAddr(awaddr);
   assign wrLegal = isWritable(wrSel);
   assign wrEn    = wrAccept && wrLegal;      // Illegal writes never reach the registers
   assign wrData  = wdata;
   assign wrStrb  = wstrb;

   assign rdSel   = decodeAddr(araddr);
   assign rdEn    = rdAccept;

   assign bvalid  = (wrState == busWriteResp);
   assign rvalid  = (rdState == busReadResp);

   // ########################################################################
   // Response channels, one pending response each
   // ########################################################################

   always_ff @(posedge selected_clk or posedge res)
   begin
      if (res)
      begin
         wrState <= busIdle;
         bresp   <= respOkay;
      end
      else if (wrAccept)
      begin
         wrState <= busWriteResp;
         bresp   <= wrLegal ? respOkay : respSlvErr;
      end
      else if (bvalid && bready)
         wrState <= busIdle;
   end

   always_ff @(posedge selected_clk or posedge res)
   begin
      if (res)
      begin
         rdState <= busIdle;
         rresp   <= respOkay;
      end
      else if (rdAccept)
      begin
         rdState <= busReadResp;
         rresp   <= (rdSel == selNone) ? respSlvErr : respOkay;
      end
      else if (rvalid && rready)
         rdState <= busIdle;
   end

endmodule

// File: design/portTimer.sv
module portTimer (
   input  logic                selected_clk,
   input  logic                res,
   input  logic                wrEn,
   input  boardPkg::regSel_t   wrSel,
   input  logic [31:0]         wrData,
   input  logic [3:0]          wrStrb,
   output logic [31:0]         portA,
   output logic [31:0]         portB,
   output logic [31:0]         portC,
   output logic [31:0]         portD,
   output logic [31:0]         ctrl,
   output logic [31:0]         arr,
   output logic [31:0]         ctr,
   output logic [31:0]         tmr,
   output logic [31:0]         status
);
   import boardPkg::*;

   logic reached;
   logic ctrHit;
   logic clearFlag;

   function automatic logic [31:0] applyStrobes(
      input logic [31:0] old,
      input logic [31:0] data,
      input logic [3:0]  strb
   );
      logic [31:0] result;
      result = old;
      for (int b = 0; b < 4; b++)
         if (strb[b])
            result[8*b +: 8] = data[8*b +: 8];
      return result;
   endfunction

   // ########################################################################
   // Writable registers
   // ########################################################################

   always_ff @(posedge selected_clk or posedge res)
   begin
      if (res)
      begin
         portA <= '0;
         portB <= '0;
         portC <= '0;
         portD <= '0;
         ctrl  <= '0;
         arr   <= '0;
      end
      else if (wrEn)
      begin
         case (wrSel)
            selPortA: portA <= applyStrobes(portA, wrData, wrStrb);
            selPortB: portB <= applyStrobes(portB, wrData, wrStrb);
            selPortC: portC <= applyStrobes(portC, wrData, wrStrb);
            selPortD: portD <= applyStrobes(portD, wrData, wrStrb);
            selCtrl:  ctrl  <= applyStrobes(ctrl, wrData, wrStrb);
            selArr:   arr   <= applyStrobes(arr, wrData, wrStrb);
            default:  ;                          // Status handled by the timer
         endcase
      end
   end

   // ########################################################################
   // Timer
   // ########################################################################

   assign ctrHit    = ctrl[0] && (ctr == arr);
   assign clearFlag = wrEn && (wrSel == selStatus) && wrStrb[0] && wrData[0];

   always_ff @(posedge selected_clk or posedge res)
   begin
      if (res)
      begin
         tmr     <= '0;
         ctr     <= '0;
         reached <= 1'b0;
      end
      else
      begin
         tmr <= tmr + 32'd1;                    // Free running
         if (ctrl[0])
         begin
            if (ctrHit)
               ctr <= '0;                        // Auto reload
            else
               ctr <= ctr + 32'd1;
         end
         // A new hit wins over a clear in the same cycle
         if (ctrHit)
            reached <= 1'b1;
         else if (clearFlag)
            reached <= 1'b0;
      end
   end

   assign status = {31'd0, reached};

endmodule

// File: design/resultSelect.sv
module resultSelect (
   input  logic                 selected_clk,
   input  logic                 res,
   input  logic                 rdEn,
   input  boardPkg::regSel_t    rdSel,
   input  logic [31:0]          portA,
   input  logic [31:0]          portB,
   input  logic [31:0]          portC,
   input  logic [31:0]          portD,
   input  logic [3:0]           buttons,
   input  logic [15:0]          switches,
   input  logic [31:0]          ctrl,
   input  logic [31:0]          arr,
   input  logic [31:0]          ctr,
   input  logic [31:0]          status,
   input  logic [31:0]          tmr,
   input  boardPkg::dispSrc_t   displaySel,
   output logic [31:0]          rdata,
   output logic [31:0]          displayData
);
   import boardPkg::*;

   logic [31:0] portI;
   logic [31:0] portJ;
   logic [31:0] readValue;

   assign portI = {28'd0, buttons};
   assign portJ = {16'd0, switches};

   // ########################################################################
   // Read data
   // ########################################################################

   always_comb
   begin
      case (rdSel)
         selPortA:  readValue = portA;
         selPortB:  readValue = portB;
         selPortC:  readValue = portC;
         selPortD:  readValue = portD;
         selPortI:  readValue = portI;
         selPortJ:  readValue = portJ;
         selCtrl:   readValue = ctrl;
         selArr:    readValue = arr;
         selCtr:    readValue = ctr;
         selStatus: readValue = status;
         selTmr:    readValue = tmr;
         default:   readValue = '0;           // Unmapped reads return zero
      endcase
   end

   // Held until the next accepted read
   always_ff @(posedge selected_clk or posedge res)
   begin
      if (res)
         rdata <= '0;
      else if (rdEn)
         rdata <= readValue;
   end

   // ########################################################################
   // Display source
   // ########################################################################

   always_comb
   begin
      case (displaySel)
         dispPortA:  displayData = portA;
         dispPortB:  displayData = portB;
         dispPortC:  displayData = portC;
         dispPortD:  displayData = portD;
         dispTmr:    displayData = tmr;
         dispArr:    displayData = arr;
         dispCtr:    displayData = ctr;
         dispStatus: displayData = status;
         dispPortI:  displayData = portI;
         dispPortJ:  displayData = portJ;
         default:    displayData = '0;
      endcase
   end

endmodule

// File: run.sh
#!/usr/bin/env bash
# Build and run the boardIo testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module boardIoTb -f sim.f \
   -Mdir obj_dir -o boardIoSim > build.log 2>&1 &&
./obj_dir/boardIoSim > sim.log 2>&1 ||
{ echo "Build or simulation error, see build.log and sim.log"; exit 1; }
cat sim.log
grep -q "Something failed" sim.log &&
{ echo "Simulation FAILED"; exit 1; } ||
{ echo "Simulation passed"; exit 0; }

// File: sim.f
design/boardPkg.sv
design/busDecode.sv
design/portTimer.sv
design/resultSelect.sv
design/boardIo.sv
testbench/boardIo_props.sv
testbench/boardIoTb.sv

// File: testbench/boardIoTb.sv
module boardIoTb;
   import boardPkg::*;

   logic        selected_clk;
   logic        res;
   logic [7:0]  awaddr;
   logic        awvalid;
   logic        awready;
   logic [31:0] wdata;
   logic [3:0]  wstrb;
   logic        wvalid;
   logic        wready;
   axiResp_t    bresp;
   logic        bvalid;
   logic        bready;
   logic [7:0]  araddr;
   logic        arvalid;
   logic        arready;
   logic [31:0] rdata;
   axiResp_t    rresp;
   logic        rvalid;
   logic        rready;
   logic [3:0]  buttons;
   logic [15:0] switches;
   logic [15:0] leds;
   dispSrc_t    displaySel;
   logic [31:0] displayData;
   logic        irq;

   string       opList[$];
   logic [31:0] colAddr[$];
   logic [31:0] colData[$];
   logic [31:0] colStrb[$];
   logic [31:0] colExp[$];
   logic [31:0] colResp[$];
   int          lineCount = 0;
   int          cycle = 0;
   int          dataErrors = 0;
   int          respErrors = 0;
   int          flagErrors = 0;
   int          otherErrors = 0;
   logic [31:0] lfsrState = 32'h3ea6_78c5;

   boardIo u_dut (.*);

   initial
   begin
      selected_clk = 1'b0;
      forever #2 selected_clk = ~selected_clk;
   end

   always @(posedge selected_clk)
      cycle <= cycle + 1;

   // ########################################################################
   // Compare tasks and stimulus helpers
   // ########################################################################

   task automatic checkData(input string what, input logic [31:0] exp, input logic [31:0] act);
      if (act !== exp)
      begin
         dataErrors++;
         $display("Error at time %0t: %s expected %h, got %h", $time, what, exp, act);
      end
   endtask

   task automatic checkResp(input string what, input axiResp_t exp, input axiResp_t act);
      if (act !== exp)
      begin
         respErrors++;
         $display("Error at time %0t: %s expected %s, got %s", $time, what, exp.name(),
                  act.name());
      end
   endtask

   task automatic checkFlag(input string what, input logic exp, input logic act);
      if (act !== exp)
      begin
         flagErrors++;
         $display("Error at time %0t: %s expected %b, got %b", $time, what, exp, act);
      end
   endtask

   function automatic logic [31:0] lfsrStep(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
   endfunction

   task automatic nextBit(output logic b);
      b = lfsrState[0];
      lfsrState = lfsrStep(lfsrState);
   endtask

   task automatic issueWrite(input logic [7:0] addr, input logic [31:0] data,
                             input logic [3:0] strb, input logic respReady);
      int  guard;
      bit  accepted;
      guard = 0;
      accepted = 0;
      @(negedge selected_clk);
      bready  = respReady;
      awaddr  = addr;
      wdata   = data;
      wstrb   = strb;
      awvalid = 1'b1;
      wvalid  = 1'b1;
      while (!accepted && guard < 20)
      begin
         #1 accepted = awready && wready;
         @(negedge selected_clk);                 // Acceptance edge passed if ready was high
         guard++;
      end
      awvalid = 1'b0;
      wvalid  = 1'b0;
      if (!accepted)
      begin
         otherErrors++;
         $display("The write to %h was never accepted", addr);
      end
   endtask

   task automatic axiWrite(input logic [7:0] addr, input logic [31:0] data,
                           input logic [3:0] strb, output axiResp_t resp);
      int guard;
      guard = 0;
      issueWrite(addr, data, strb, 1'b1);
      while (!bvalid && guard < 20)
      begin
         @(negedge selected_clk);
         guard++;
      end
      if (!bvalid)
      begin
         otherErrors++;
         $display("No write response came for address %h", addr);
      end
      resp = bresp;
   endtask

   task automatic axiRead(input logic [7:0] addr, output logic [31:0] data,
                          output axiResp_t resp);
      int  guard;
      bit  accepted;
      guard = 0;
      accepted = 0;
      @(negedge selected_clk);
      rready  = 1'b1;
      araddr  = addr;
      arvalid = 1'b1;
      while (!accepted && guard < 20)
      begin
         #1 accepted = arready;
         @(negedge selected_clk);
         guard++;
      end
      arvalid = 1'b0;
      if (!accepted || !rvalid)
      begin
         otherErrors++;
         $display("The read from %h got no response", addr);
      end
      data = rdata;
      resp = rresp;
   endtask

   task automatic stallWrite(input logic [7:0] addr, input logic [31:0] data,
                             input logic [3:0] strb, input axiResp_t expResp);
      issueWrite(addr, data, strb, 1'b0);
      checkResp("stalled write response", expResp, bresp);
      awvalid = 1'b1;                             // Second write must wait
      wvalid  = 1'b1;
      wdata   = ~data;
      for (int i = 0; i < 5; i++)
      begin
         #1;
         checkFlag("bvalid while stalled", 1'b1, bvalid);
         checkResp("bresp while stalled", expResp, bresp);
         checkFlag("awready while stalled", 1'b0, awready);
         @(negedge selected_clk);
      end
      awvalid = 1'b0;
      wvalid  = 1'b0;
      bready  = 1'b1;
      @(negedge selected_clk);
      checkFlag("bvalid after release", 1'b0, bvalid);
   endtask

   task automatic stallRead(input logic [7:0] addr, input logic [31:0] expData,
                            input axiResp_t expResp);
      logic [31:0] data;
      axiResp_t    resp;
      axiRead(addr, data, resp);                  // axiRead leaves rready high
      rready = 1'b0;
      checkData("stalled read data", expData, data);
      checkResp("stalled read response", expResp, resp);
      @(negedge selected_clk);
      araddr  = 8'h00;
      arvalid = 1'b1;
      for (int i = 0; i < 5; i++)
      begin
         #1;
         checkFlag("rvalid while stalled", 1'b1, rvalid);
         checkData("rdata while stalled", expData, rdata);
         checkResp("rresp while stalled", expResp, rresp);
         checkFlag("arready while stalled", 1'b0, arready);
         @(negedge selected_clk);
      end
      arvalid = 1'b0;
      rready  = 1'b1;
      @(negedge selected_clk);
      checkFlag("rvalid after release", 1'b0, rvalid);
   endtask

   // ########################################################################
   // Pattern reader and main sequence
   // ########################################################################

   task automatic loadPatterns();
      int    fd;
      int    n;
      string line;
      string op;
      logic [31:0] a;
      logic [31:0] d;
      logic [31:0] s;
      logic [31:0] e;
      logic [31:0] r;
      fd = $fopen("testbench/boardIo_patterns.txt", "r");
      if (fd == 0)
      begin
         otherErrors++;
         $display("Could not open the pattern file");
         return;
      end
      while ($fgets(line, fd))
      begin
         if (line.len() < 2 || line[0] == "#")
            continue;
         n = $sscanf(line, "%s %h %h %h %h %h", op, a, d, s, e, r);
         if (n != 6)
            continue;
         opList.push_back(op);
         colAddr.push_back(a);
         colData.push_back(d);
         colStrb.push_back(s);
         colExp.push_back(e);
         colResp.push_back(r);
      end
      $fclose(fd);
      lineCount = opList.size();
   endtask

   task automatic runLine(input int i);
      logic [31:0] data;
      logic [31:0] first;
      logic [31:0] expData;
      axiResp_t    resp;
      axiResp_t    expResp;
      int          start;
      expResp = axiResp_t'(colResp[i][1:0]);
      case (opList[i])
         "write":
         begin
            axiWrite(colAddr[i][7:0], colData[i], colStrb[i][3:0], resp);
            checkResp($sformatf("write %h", colAddr[i]), expResp, resp);
         end
         "read":
         begin
            axiRead(colAddr[i][7:0], data, resp);
            checkData($sformatf("read %h", colAddr[i]), colExp[i], data);
            checkResp($sformatf("read %h", colAddr[i]), expResp, resp);
         end
         "setInputs":
         begin
            @(negedge selected_clk);
            for (int b = 0; b < 16; b++)
               nextBit(switches[b]);
            for (int b = 0; b < 4; b++)
               nextBit(buttons[b]);
         end
         "readInputs":
         begin
            axiRead(8'h10, data, resp);
            checkData("portI", {28'd0, buttons}, data);
            checkResp("portI", respOkay, resp);
            axiRead(8'h14, data, resp);
            checkData("portJ", {16'd0, switches}, data);
            checkResp("portJ", respOkay, resp);
         end
         "leds":
         begin
            @(negedge selected_clk);
            checkData("leds", colExp[i], {16'd0, leds});
         end
         "waitFlag":
         begin
            start = cycle;
            data = '0;
            while (!data[0] && cycle - start < 100)
               axiRead(8'h24, data, resp);
            if (!data[0])
            begin
               otherErrors++;
               $display("The timer flag was not set within 100 cycles");
            end
         end
         "irq":
         begin
            @(negedge selected_clk);
            checkFlag("irq", colExp[i][0], irq);
         end
         "readMax":
         begin
            axiRead(colAddr[i][7:0], data, resp);
            if (data > colExp[i])
               checkData("ctr bound", colExp[i], data);
         end
         "tmrRise":
         begin
            axiRead(colAddr[i][7:0], first, resp);
            axiRead(colAddr[i][7:0], data, resp);
            if (data <= first)
               checkData("tmr increase", first + 1, data);
         end
         "display":
         begin
            @(negedge selected_clk);
            displaySel = dispSrc_t'(colAddr[i][3:0]);
            if (colAddr[i][3:0] == 4'd8)
               expData = {28'd0, buttons};
            else if (colAddr[i][3:0] == 4'd9)
               expData = {16'd0, switches};
            else
               expData = colExp[i];
            #1 checkData($sformatf("display %0d", colAddr[i]), expData, displayData);
         end
         "stallWrite": stallWrite(colAddr[i][7:0], colData[i], colStrb[i][3:0], expResp);
         "stallRead":  stallRead(colAddr[i][7:0], colExp[i], expResp);
         default:
         begin
            otherErrors++;
            $display("Unknown operation %s in the pattern file", opList[i]);
         end
      endcase
   endtask

   initial
   begin
      res = 1'b1;
      awaddr = '0;
      awvalid = 1'b0;
      wdata = '0;
      wstrb = '0;
      wvalid = 1'b0;
      bready = 1'b1;
      araddr = '0;
      arvalid = 1'b0;
      rready = 1'b1;
      buttons = '0;
      switches = '0;
      displaySel = dispPortA;
      loadPatterns();
      repeat (16) @(posedge selected_clk);
      @(negedge selected_clk);
      res = 1'b0;
      for (int i = 0; i < lineCount; i++)
         runLine(i);
      repeat (2) @(negedge selected_clk);
      $display("Errors: data %0d, response %0d, flag %0d, other %0d",
               dataErrors, respErrors, flagErrors, otherErrors);
      if (dataErrors + respErrors + flagErrors + otherErrors == 0 && lineCount > 0)
         $display("Everything OK");
      else
         $display("Something failed");
      $finish;
   end

   // Watchdog sized by the pattern count
   initial
   begin
      wait (lineCount > 0);
      #(lineCount * 400 + 16 * 4);
      $display("Timeout: the tests did not finish in time");
      $display("Something failed");
      $finish;
   end

endmodule

// File: testbench/boardIo_patterns.txt
# op addr data strb expData expResp, all hex, unused columns 0
# display puts the source code in the addr column
write 00 11223344 f 0 0
write 00 aabbccdd 5 0 0
read 00 0 0 11bb33dd 0
write 04 00005a5a 3 0 0
write 04 ffffffff 8 0 0
read 04 0 0 ff005a5a 0
leds 0 0 0 00005a5a 0
write 08 cafef00d f 0 0
write 0c 12345678 c 0 0
read 0c 0 0 12340000 0
setInputs 0 0 0 0 0
readInputs 0 0 0 0 0
write 10 ffffffff f 0 2
write 14 ffffffff f 0 2
readInputs 0 0 0 0 0
write 30 ffffffff f 0 2
read 30 0 0 0 2
write 1c 14 f 0 0
write 18 1 1 0 0
waitFlag 0 0 0 0 0
irq 0 0 0 1 0
readMax 20 0 0 14 0
write 18 0 f 0 0
write 24 1 f 0 0
irq 0 0 0 0 0
tmrRise 28 0 0 0 0
display 0 0 0 11bb33dd 0
display 1 0 0 ff005a5a 0
display 2 0 0 cafef00d 0
display 3 0 0 12340000 0
display 5 0 0 14 0
display 7 0 0 0 0
display 8 0 0 0 0
display 9 0 0 0 0
display c 0 0 0 0
stallWrite 08 0badf00d f 0 0
stallRead 1c 0 0 14 0
read 08 0 0 0badf00d 0

// File: testbench/boardIo_props.sv
module busDecodeProps (
   input logic                selected_clk,
   input logic                res,
   input logic                awready,
   input logic                wready,
   input logic                arready,
   input logic                bvalid,
   input logic                bready,
   input boardPkg::axiResp_t  bresp,
   input logic                rvalid,
   input logic                rready,
   input boardPkg::busState_t wrState,
   input boardPkg::busState_t rdState
);
   import boardPkg::*;

   readyPair: assert property (@(posedge selected_clk) disable iff (res)
      awready == wready)
      else $error("awready and wready differ");

   bHold: assert property (@(posedge selected_clk) disable iff (res)
      bvalid && !bready |=> bvalid && $stable(bresp))
      else $error("Write response dropped or changed before bready");

   rHold: assert property (@(posedge selected_clk) disable iff (res)
      rvalid && !rready |=> rvalid)
      else $error("Read response dropped before rready");

   resetQuiet: assert property (@(posedge selected_clk)
      res |-> !awready && !wready && !arready && !bvalid && !rvalid
              && wrState == busIdle && rdState == busIdle)
      else $error("Handshake output active during reset");

endmodule

bind busDecode busDecodeProps props (.*);
